// File: common/cpuPkg.sv
// CPU shared types
package cpuPkg;

    // data word, fixed at 16 bits
    typedef logic [15:0] wordT;

    // one of eight registers
    typedef logic [2:0] regIdxT;

    typedef logic [3:0] opcodeT;

    // immediate field of the instruction word
    typedef logic [5:0] immT;

    // operation codes, numbered in order
    localparam opcodeT OP_NOP = 4'd0;
    localparam opcodeT OP_ADD = 4'd1;
    localparam opcodeT OP_SUB = 4'd2;
    localparam opcodeT OP_AND = 4'd3;
    localparam opcodeT OP_OR  = 4'd4;
    localparam opcodeT OP_NOT = 4'd5;
    localparam opcodeT OP_INC = 4'd6;
    localparam opcodeT OP_DEC = 4'd7;
    localparam opcodeT OP_SHL = 4'd8;
    localparam opcodeT OP_SHR = 4'd9;
    localparam opcodeT OP_IN  = 4'd10;
    localparam opcodeT OP_OUT = 4'd11;
    localparam opcodeT OP_LDM = 4'd12;

    // opcode sits in the top four bits
    typedef struct packed {
        opcodeT opcode;
        regIdxT dst;
        regIdxT src;
        immT    imm;
    } instrT;

    // bit 0 zero, bit 1 negative, bit 2 carry
    typedef struct packed {
        logic carry;
        logic negative;
        logic zero;
    } ccrT;

    // alu output on its way to the register file
    typedef struct packed {
        cpuPkg::wordT result;
        cpuPkg::ccrT  flags;
    } execResultT;

endpackage

// File: src/alu/aluUnit.sv
// Combinational ALU
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::opcodeT     op,
    input  cpuPkg::wordT       srcVal,
    input  cpuPkg::wordT       dstVal,
    input  cpuPkg::immT        imm,
    input  cpuPkg::wordT       inPort,
    output cpuPkg::execResultT res
);

    // 17-bit sum, top bit is the add carry
    logic [16:0] sum;
    cpuPkg::wordT result;
    // shift amount from low nibble of src
    logic [3:0] shAmt;

    assign sum   = {1'b0, dstVal} + {1'b0, srcVal};
    assign shAmt = srcVal[3:0];

    always_comb begin
        case (op)
            cpuPkg::OP_ADD: result = sum[15:0];
            cpuPkg::OP_SUB: result = dstVal - srcVal;
            cpuPkg::OP_AND: result = dstVal & srcVal;
            cpuPkg::OP_OR:  result = dstVal | srcVal;
            cpuPkg::OP_NOT: result = ~dstVal;
            cpuPkg::OP_INC: result = dstVal + 16'd1;
            cpuPkg::OP_DEC: result = dstVal - 16'd1;
            // logical shifts, zero fill
            cpuPkg::OP_SHL: result = dstVal << shAmt;
            cpuPkg::OP_SHR: result = dstVal >> shAmt;
            cpuPkg::OP_IN:  result = inPort;
            // out passes dst straight to the port
            cpuPkg::OP_OUT: result = dstVal;
            cpuPkg::OP_LDM: result = {10'd0, imm};
            default:        result = '0;
        endcase
    end

    assign res.result = result;

    // zero and negative from every result
    assign res.flags.zero     = (result == '0);
    assign res.flags.negative = result[15];
    // carry only meaningful on add
    assign res.flags.carry    = (op == cpuPkg::OP_ADD) && sum[16];

endmodule

// File: src/regFile.sv
// Register file and CCR
`timescale 1ns/1ps

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::regIdxT     rdA,
    input  cpuPkg::regIdxT     rdB,
    output cpuPkg::wordT       valA,
    output cpuPkg::wordT       valB,
    input  logic               wrEn,
    input  cpuPkg::regIdxT     wrIdx,
    input  cpuPkg::execResultT wrData,
    input  logic               ccrEn,
    output cpuPkg::ccrT        ccr
);

    cpuPkg::wordT regs [8];

    // two async read ports
    assign valA = regs[rdA];
    assign valB = regs[rdB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            ccr <= '0;
        end else begin
            if (wrEn) begin
                regs[wrIdx] <= wrData.result;
            end
            // flags load independently of the word write
            if (ccrEn) begin
                ccr <= wrData.flags;
            end
        end
    end

endmodule

// File: src/instrQueue.sv
// Instruction FIFO
`timescale 1ns/1ps

module instrQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          push,
    input  cpuPkg::instrT pushData,
    input  logic          pop,
    output cpuPkg::instrT head,
    output logic          empty
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    cpuPkg::instrT mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    // occupancy, source credits keep it within depth
    logic [CNT_W-1:0] count;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head  = mem[rdPtr];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // push and pop together leave count alone
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

// File: src/creditCounter.sv
// Output credit counter
`timescale 1ns/1ps

module creditCounter #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic take,
    input  logic give,
    output logic avail
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    // credits currently held by the core
    logic [CNT_W-1:0] count;

    assign avail = (count != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({take, give})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                // both or neither, no change
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/controlFsm.sv
// Fetch and execute control
`timescale 1ns/1ps

module controlFsm (
    input  logic          clk,
    input  logic          rstN,
    input  logic          empty,
    input  cpuPkg::instrT head,
    input  logic          avail,
    output logic          pop,
    output logic          instrCredit,
    output cpuPkg::instrT cur,
    output logic          wrEn,
    output logic          ccrEn,
    output logic          take,
    output logic          outValid
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        WAIT_OUT
    } stateT;

    stateT state;
    stateT nextState;

    logic popNow;
    logic isNop;
    logic isOut;
    // out instruction leaving with a credit this cycle
    logic outFire;

    assign isNop = (cur.opcode == cpuPkg::OP_NOP);
    assign isOut = (cur.opcode == cpuPkg::OP_OUT);

    // head leaves the queue in fetch when one is there
    assign popNow      = (state == FETCH) && !empty;
    assign pop         = popNow;
    // one credit back to the source per popped instruction
    assign instrCredit = popNow;

    assign outFire = ((state == EXEC) || (state == WAIT_OUT)) && isOut && avail;
    assign outValid = outFire;
    assign take     = outFire;

    // writeback for everything except nop and out
    assign wrEn  = (state == EXEC) && !isNop && !isOut;
    // out updates flags only when it actually leaves
    assign ccrEn = ((state == EXEC) && !isNop && !isOut) || outFire;

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (!empty) begin
                    nextState = EXEC;
                end
            end
            EXEC: begin
                // no output credit, park until the sink returns one
                if (isOut && !avail) begin
                    nextState = WAIT_OUT;
                end else begin
                    nextState = FETCH;
                end
            end
            WAIT_OUT: begin
                if (avail) begin
                    nextState = FETCH;
                end
            end
            default: nextState = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    // instruction under execution
    always_ff @(posedge clk) begin
        if (popNow) begin
            cur <= head;
        end
    end

endmodule

// File: src/cpuCore.sv
// Accumulator CPU core
`timescale 1ns/1ps

module cpuCore #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          instrValid,
    input  cpuPkg::instrT instrWord,
    output logic          instrCredit,
    input  cpuPkg::wordT  inPort,
    output logic          outValid,
    output cpuPkg::wordT  outData,
    input  logic          outCredit,
    output cpuPkg::ccrT   ccr
);

    logic               pop;
    logic               empty;
    cpuPkg::instrT      head;
    cpuPkg::instrT      cur;
    logic               avail;
    logic               take;
    logic               wrEn;
    logic               ccrEn;
    // src operand and dst operand
    cpuPkg::wordT       srcVal;
    cpuPkg::wordT       dstVal;
    cpuPkg::execResultT aluRes;

    instrQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) instrQueue_inst (
        .clk     (clk),
        .rstN    (rstN),
        .push    (instrValid),
        .pushData(instrWord),
        .pop     (pop),
        .head    (head),
        .empty   (empty)
    );

    controlFsm controlFsm_inst (
        .clk        (clk),
        .rstN       (rstN),
        .empty      (empty),
        .head       (head),
        .avail      (avail),
        .pop        (pop),
        .instrCredit(instrCredit),
        .cur        (cur),
        .wrEn       (wrEn),
        .ccrEn      (ccrEn),
        .take       (take),
        .outValid   (outValid)
    );

    // sink returns credits on outCredit
    creditCounter #(
        .OUT_CREDITS(OUT_CREDITS)
    ) creditCounter_inst (
        .clk  (clk),
        .rstN (rstN),
        .take (take),
        .give (outCredit),
        .avail(avail)
    );

    regFile regFile_inst (
        .clk   (clk),
        .rstN  (rstN),
        .rdA   (cur.src),
        .rdB   (cur.dst),
        .valA  (srcVal),
        .valB  (dstVal),
        .wrEn  (wrEn),
        .wrIdx (cur.dst),
        .wrData(aluRes),
        .ccrEn (ccrEn),
        .ccr   (ccr)
    );

    aluUnit aluUnit_inst (
        .op    (cur.opcode),
        .srcVal(srcVal),
        .dstVal(dstVal),
        .imm   (cur.imm),
        .inPort(inPort),
        .res   (aluRes)
    );

    // out port reads the alu result directly
    assign outData = aluRes.result;

endmodule

// File: bench/cpuCore_assert.sv
// Core credit and reset checks
`timescale 1ns/1ps

module cpuCore_assert #(
    parameter int OUT_CREDITS = 2,
    parameter int CNT_W = $clog2(OUT_CREDITS + 1)
) (
    input logic             clk,
    input logic             rstN,
    input logic             instrCredit,
    input logic             outValid,
    input logic             outCredit,
    input logic [CNT_W-1:0] creditCount
);

    // failures seen so far, watched by the bench
    int errCount = 0;

    // credits held by the core, tracked from the port handshakes alone
    int portCredits;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            portCredits <= OUT_CREDITS;
        end else begin
            portCredits <= portCredits - int'(outValid) + int'(outCredit);
        end
    end

    // no output without a credit in hand
    outNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> portCredits > 0)
        else begin
            $error("outValid high with no output credit");
            errCount++;
        end

    // sink can never give back more than it got
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        int'(creditCount) <= OUT_CREDITS)
        else begin
            $error("output credit count above its reset value");
            errCount++;
        end

    // quiet handshakes during reset and the cycle after
    resetQuiet: assert property (@(posedge clk) !rstN |=> (!instrCredit && !outValid))
        else begin
            $error("handshake active during or right after reset");
            errCount++;
        end

endmodule

bind cpuCore cpuCore_assert #(
    .OUT_CREDITS(OUT_CREDITS)
) cpuCore_assert_inst (
    .clk        (clk),
    .rstN       (rstN),
    .instrCredit(instrCredit),
    .outValid   (outValid),
    .outCredit  (outCredit),
    .creditCount(creditCounter_inst.count)
);

// File: bench/cpuTb.sv
// CPU core testbench
`timescale 1ns/1ps

module cpuTb;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int WAIT_LIMIT  = 400;

    logic          clk;
    logic          rstN;
    logic          instrValid;
    cpuPkg::instrT instrWord;
    logic          instrCredit;
    cpuPkg::wordT  inPort;
    logic          outValid;
    cpuPkg::wordT  outData;
    logic          outCredit;
    cpuPkg::ccrT   ccr;

    // galois lfsr state
    logic [15:0] lfsr = 16'd46;

    // source bookkeeping
    int            srcCredits;
    int            sentCnt;
    int            creditCnt;
    cpuPkg::instrT sentQ[$];

    // reference model and pending checks
    cpuPkg::wordT mRegs [8];
    cpuPkg::ccrT  mCcr;
    cpuPkg::wordT expOut[$];
    int           chkDue[$];
    cpuPkg::ccrT  chkCcr[$];
    int           cycleCnt;
    int           outCount;
    int           carrySeen;
    int           zeroSeen;

    // sink side, one delay per held credit
    logic sinkHold;
    int   delayQ[$];

    cpuCore #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) cpuCore_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .instrCredit(instrCredit),
        .inPort     (inPort),
        .outValid   (outValid),
        .outData    (outData),
        .outCredit  (outCredit),
        .ccr        (ccr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // one lfsr step per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic cpuPkg::instrT makeInstr(input cpuPkg::opcodeT op,
                                                input cpuPkg::regIdxT dst,
                                                input cpuPkg::regIdxT src,
                                                input cpuPkg::immT imm);
        cpuPkg::instrT ins;
        ins.opcode = op;
        ins.dst = dst;
        ins.src = src;
        ins.imm = imm;
        return ins;
    endfunction

    function automatic bit pipeBusy();
        return sentQ.size() > 0 || expOut.size() > 0 || chkDue.size() > 0
            || delayQ.size() > 0;
    endfunction

    // retire one instruction in the model, in pop order
    task automatic modelStep(input cpuPkg::instrT ins);
        cpuPkg::wordT d;
        cpuPkg::wordT s;
        cpuPkg::wordT r;
        logic [16:0]  wide;
        cpuPkg::ccrT  f;
        d = mRegs[ins.dst];
        s = mRegs[ins.src];
        wide = {1'b0, d} + {1'b0, s};
        f = '0;
        r = d;
        case (ins.opcode)
            cpuPkg::OP_ADD: begin
                r = wide[15:0];
                f.carry = wide[16];
            end
            cpuPkg::OP_SUB: r = d - s;
            cpuPkg::OP_AND: r = d & s;
            cpuPkg::OP_OR:  r = d | s;
            cpuPkg::OP_NOT: r = ~d;
            cpuPkg::OP_INC: r = d + 16'd1;
            cpuPkg::OP_DEC: r = d - 16'd1;
            cpuPkg::OP_SHL: r = d << s[3:0];
            cpuPkg::OP_SHR: r = d >> s[3:0];
            cpuPkg::OP_IN:  r = inPort;
            cpuPkg::OP_LDM: r = {10'd0, ins.imm};
            default:        r = d;
        endcase
        f.zero = (r == '0);
        f.negative = r[15];
        if (ins.opcode != cpuPkg::OP_NOP) begin
            mCcr = f;
            carrySeen += int'(f.carry);
            zeroSeen += int'(ins.opcode == cpuPkg::OP_SUB && f.zero);
        end
        if (ins.opcode == cpuPkg::OP_OUT) begin
            expOut.push_back(r);
        end else begin
            // flags visible two cycles after the credit pulse
            chkDue.push_back(cycleCnt + 2);
            chkCcr.push_back(mCcr);
            if (ins.opcode != cpuPkg::OP_NOP) begin
                mRegs[ins.dst] = r;
            end
        end
    endtask

    // called at posedge plus 1 ns, returns aligned the same way
    task automatic sendInstr(input cpuPkg::instrT ins);
        int waited;
        waited = 0;
        instrValid = 1'b0;
        while (srcCredits == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (srcCredits == 0) begin
            abortRun("source waited too long for an instruction credit");
        end else begin
            instrValid = 1'b1;
            instrWord = ins;
            srcCredits--;
            sentCnt++;
            sentQ.push_back(ins);
            @(posedge clk);
            #1;
            instrValid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (pipeBusy() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pipeBusy()) begin
            abortRun("pending instructions or outputs did not drain in time");
        end
    endtask

    // sink returns held credits after its chosen delay
    initial begin
        forever begin
            @(posedge clk);
            #1;
            outCredit = 1'b0;
            if (!sinkHold && delayQ.size() > 0) begin
                if (delayQ[0] == 0) begin
                    outCredit = 1'b1;
                    void'(delayQ.pop_front());
                end else begin
                    delayQ[0] = delayQ[0] - 1;
                end
            end
        end
    end

    // monitor on the falling edge, outputs settled
    initial begin
        forever begin
            @(negedge clk);
            if (rstN) begin
                cycleCnt++;
                assert (cpuCore_inst.cpuCore_assert_inst.errCount == 0)
                    else abortRun("a bound assertion on the core failed");
                while (chkDue.size() > 0 && chkDue[0] == cycleCnt) begin
                    assert (ccr == chkCcr[0]) else abortRun($sformatf(
                        "Error at %0t: ccr %b, expected %b", $time, ccr, chkCcr[0]));
                    void'(chkDue.pop_front());
                    void'(chkCcr.pop_front());
                end
                if (outValid) begin
                    outCount++;
                    assert (expOut.size() > 0)
                        else abortRun("outValid rose with no output pending");
                    assert (outData == expOut[0]) else abortRun($sformatf(
                        "Error at %0t: outData %h, expected %h", $time, outData, expOut[0]));
                    void'(expOut.pop_front());
                    delayQ.push_back(int'(randBits(2)));
                end
                if (instrCredit) begin
                    assert (sentQ.size() > 0)
                        else abortRun("instrCredit pulsed with no instruction outstanding");
                    creditCnt++;
                    srcCredits++;
                    modelStep(sentQ.pop_front());
                end
            end
        end
    end

    initial begin
        cpuPkg::immT    imm;
        cpuPkg::opcodeT op;
        cpuPkg::regIdxT dst;
        cpuPkg::regIdxT src;
        int             base;
        int             waited;
        rstN = 1'b0;
        instrValid = 1'b0;
        instrWord = '0;
        inPort = '0;
        outCredit = 1'b0;
        sinkHold = 1'b0;
        srcCredits = QUEUE_DEPTH;
        sentCnt = 0;
        creditCnt = 0;
        cycleCnt = 0;
        outCount = 0;
        carrySeen = 0;
        zeroSeen = 0;
        mCcr = '0;
        for (int i = 0; i < 8; i++) begin
            mRegs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        // held for the whole run
        inPort = randBits(16);

        // idle core before the first instruction
        repeat (4) begin
            @(negedge clk);
            assert (!instrCredit && !outValid && ccr == '0) else abortRun($sformatf(
                "Error at %0t: core not idle after reset", $time));
        end
        @(posedge clk);
        #1;

        // ldm then out, immediates come back in order
        for (int k = 0; k < 6; k++) begin
            imm = cpuPkg::immT'(randBits(6));
            sendInstr(makeInstr(cpuPkg::OP_LDM, cpuPkg::regIdxT'(k), 3'd0, imm));
            sendInstr(makeInstr(cpuPkg::OP_OUT, cpuPkg::regIdxT'(k), 3'd0, 6'd0));
        end
        waitDrain();

        // 0xf000 doubled sets carry, r3 minus r3 sets zero
        sendInstr(makeInstr(cpuPkg::OP_LDM, 3'd1, 3'd0, 6'd63));
        sendInstr(makeInstr(cpuPkg::OP_LDM, 3'd2, 3'd0, 6'd12));
        sendInstr(makeInstr(cpuPkg::OP_SHL, 3'd1, 3'd2, 6'd0));
        sendInstr(makeInstr(cpuPkg::OP_ADD, 3'd1, 3'd1, 6'd0));
        sendInstr(makeInstr(cpuPkg::OP_SUB, 3'd3, 3'd3, 6'd0));
        sendInstr(makeInstr(cpuPkg::OP_OUT, 3'd1, 3'd0, 6'd0));
        waitDrain();

        // random mix at full rate, each result sent out
        for (int k = 0; k < 40; k++) begin
            op = cpuPkg::opcodeT'(randBits(4) % 16'd13);
            dst = cpuPkg::regIdxT'(randBits(3));
            src = cpuPkg::regIdxT'(randBits(3));
            imm = cpuPkg::immT'(randBits(6));
            sendInstr(makeInstr(op, dst, src, imm));
            sendInstr(makeInstr(cpuPkg::OP_OUT, dst, 3'd0, 6'd0));
        end
        waitDrain();

        // sink holds back, only the reset credits get used
        @(negedge clk);
        sinkHold = 1'b1;
        base = outCount;
        @(posedge clk);
        #1;
        for (int k = 0; k < 4; k++) begin
            imm = cpuPkg::immT'(randBits(6));
            sendInstr(makeInstr(cpuPkg::OP_LDM, cpuPkg::regIdxT'(k), 3'd0, imm));
            sendInstr(makeInstr(cpuPkg::OP_OUT, cpuPkg::regIdxT'(k), 3'd0, 6'd0));
        end
        waited = 0;
        while (outCount < base + OUT_CREDITS && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (outCount >= base + OUT_CREDITS)
            else abortRun("the reset output credits were never used");
        // stalled window, queue must stop draining
        repeat (20) @(posedge clk);
        #1;
        assert (outCount == base + OUT_CREDITS) else abortRun($sformatf(
            "Error at %0t: %0d outputs while held, expected %0d", $time,
            outCount - base, OUT_CREDITS));
        assert (creditCnt == sentCnt - 2) else abortRun($sformatf(
            "Error at %0t: %0d credits while stalled, expected %0d", $time,
            creditCnt, sentCnt - 2));
        @(negedge clk);
        sinkHold = 1'b0;
        @(posedge clk);
        #1;
        waitDrain();

        if (carrySeen > 0 && zeroSeen > 0 && creditCnt == sentCnt) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun($sformatf("Error at %0t: carry %0d, zero %0d, credits %0d of %0d",
                $time, carrySeen, zeroSeen, creditCnt, sentCnt));
        end
    end

endmodule

// File: flist.f
common/cpuPkg.sv
src/alu/aluUnit.sv
src/regFile.sv
src/instrQueue.sv
src/creditCounter.sv
src/controlFsm.sv
src/cpuCore.sv
bench/cpuCore_assert.sv
bench/cpuTb.sv

// File: Makefile
TOP = cpuTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim

run: compile
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
